/* hdl/lsu_pkg.sv */
// Widths and AHB size codes for the LSU; only naturally aligned accesses are supported
package lsu_pkg;

   //==========================================================================
   // Widths
   //==========================================================================

   localparam int DATA_WIDTH    = 32;
   localparam int HALF_WIDTH    = 16;
   localparam int BYTE_WIDTH    = 8;
   localparam int REG_IDX_WIDTH = 5;
   localparam int HSIZE_WIDTH   = 3;

   // Byte offset inside a word, from the low address bits
   localparam int LANE_WIDTH    = 2;

   //==========================================================================
   // Types
   //==========================================================================

   // Data or address word
   typedef logic [DATA_WIDTH-1:0]    word_t;

   // Destination register number
   typedef logic [REG_IDX_WIDTH-1:0] reg_idx_t;

   // Byte lane within a word
   typedef logic [LANE_WIDTH-1:0]    lane_t;

   // AHB HSIZE field
   typedef logic [HSIZE_WIDTH-1:0]   hsize_t;

   //==========================================================================
   // Transfer sizes, AHB encoding
   //==========================================================================

   localparam hsize_t SIZE_BYTE = 3'd0;
   localparam hsize_t SIZE_HALF = 3'd1;
   localparam hsize_t SIZE_WORD = 3'd2;

   // Larger AHB sizes are never issued by this unit
   // A halfword must have addr[0] clear, a word addr[1:0] clear

endpackage : lsu_pkg

/* hdl/lsu_addr_phase.sv */
// Address phase follows the request combinationally; the core must hold it stable while hreadyd is low
`timescale 1ns/1ps

module lsu_addr_phase
   import lsu_pkg::*;
(
   input  logic     clk,
   input  logic     rst_n,

   // Core request
   input  logic     req,
   input  logic     write,
   input  logic     unsigned_ld,
   input  hsize_t   size,
   input  word_t    addr,
   input  reg_idx_t rd_idx,

   // Bus
   input  logic     hreadyd,
   output word_t    haddrd,
   output logic     htransd,
   output logic     hwrited,
   output hsize_t   hsized,

   // Acceptance and captured data-phase attributes
   output logic     accept,
   output logic     ph_load,
   output lane_t    ph_lane,
   output hsize_t   ph_size,
   output logic     ph_unsigned,
   output reg_idx_t ph_rd
);

   //==========================================================================
   // Address phase
   //==========================================================================

   assign haddrd  = addr;
   assign htransd = req;
   assign hwrited = req & write;
   assign hsized  = size;

   // Transfer is taken by the slave when the previous data phase completes
   assign accept  = req & hreadyd;

   //==========================================================================
   // Data-phase attributes
   //==========================================================================

   // Load flag tracks whether the pending data phase needs a writeback.
   // It drops when the data phase ends with no new load behind it
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ph_load <= 1'b0;
      end else if (hreadyd) begin
         ph_load <= accept & ~write;
      end
   end

   // Payload of the access, held across wait states
   always_ff @(posedge clk) begin
      if (accept) begin
         ph_lane     <= addr[LANE_WIDTH-1:0];
         ph_size     <= size;
         ph_unsigned <= unsigned_ld;
         ph_rd       <= rd_idx;
      end
   end

endmodule : lsu_addr_phase

/* hdl/lsu_store_align.sv */
// Store data is aligned from the request lane; misaligned halfwords or words are not handled
`timescale 1ns/1ps

module lsu_store_align
   import lsu_pkg::*;
(
   input  logic   clk,
   input  logic   rst_n,

   input  logic   accept,
   input  hsize_t size,
   input  lane_t  lane,
   input  word_t  wdata,

   output word_t  hwdatad
);

   word_t aligned;

   //==========================================================================
   // Byte lane placement
   //==========================================================================

   // Unused lanes are driven to zero
   always_comb begin
      case (size)
         SIZE_BYTE: begin
            aligned = word_t'(wdata[BYTE_WIDTH-1:0]) << (lane * BYTE_WIDTH);
         end
         SIZE_HALF: begin
            // Only lane bit 1 matters for a halfword
            aligned = word_t'(wdata[HALF_WIDTH-1:0]) << (lane[1] * HALF_WIDTH);
         end
         default: begin
            aligned = wdata;
         end
      endcase
   end

   //==========================================================================
   // Data-phase write data
   //==========================================================================

   // Loaded with the address phase, held through wait states
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         hwdatad <= '0;
      end else if (accept) begin
         hwdatad <= aligned;
      end
   end

endmodule : lsu_store_align

/* hdl/lsu_load_extract.sv */
// Load result is combinational from hrdatad and valid only in the ready cycle of the data phase
`timescale 1ns/1ps

module lsu_load_extract
   import lsu_pkg::*;
(
   // Captured attributes of the access in its data phase
   input  logic     ph_load,
   input  lane_t    ph_lane,
   input  hsize_t   ph_size,
   input  logic     ph_unsigned,
   input  reg_idx_t ph_rd,

   // Bus
   input  word_t    hrdatad,
   input  logic     hreadyd,

   // Writeback to the core
   output logic     load_valid,
   output word_t    load_data,
   output reg_idx_t load_rd
);

   logic [BYTE_WIDTH-1:0] byte_sel;
   logic [HALF_WIDTH-1:0] half_sel;
   logic                  byte_fill;
   logic                  half_fill;

   //==========================================================================
   // Lane selection
   //==========================================================================

   assign byte_sel = hrdatad[ph_lane * BYTE_WIDTH +: BYTE_WIDTH];
   assign half_sel = hrdatad[ph_lane[1] * HALF_WIDTH +: HALF_WIDTH];

   // Fill bit is the MSB for signed loads, zero otherwise
   assign byte_fill = ~ph_unsigned & byte_sel[BYTE_WIDTH-1];
   assign half_fill = ~ph_unsigned & half_sel[HALF_WIDTH-1];

   //==========================================================================
   // Extension
   //==========================================================================

   always_comb begin
      case (ph_size)
         SIZE_BYTE: begin
            load_data = {{(DATA_WIDTH-BYTE_WIDTH){byte_fill}}, byte_sel};
         end
         SIZE_HALF: begin
            load_data = {{(DATA_WIDTH-HALF_WIDTH){half_fill}}, half_sel};
         end
         default: begin
            load_data = hrdatad;
         end
      endcase
   end

   //==========================================================================
   // Writeback
   //==========================================================================

   // One pulse per load, in the cycle the slave completes it
   assign load_valid = ph_load & hreadyd;
   assign load_rd    = ph_rd;

endmodule : lsu_load_extract

/* hdl/lsu_top.sv */
// AHB-Lite style data port without HRESP handling; requests must be naturally aligned
`timescale 1ns/1ps

module lsu_top
   import lsu_pkg::*;
(
   input  logic     clk,
   input  logic     rst_n,

   // Core request
   input  logic     req,
   input  logic     write,
   input  hsize_t   size,
   input  logic     unsigned_ld,
   input  word_t    addr,
   input  word_t    wdata,
   input  reg_idx_t rd_idx,

   // Data bus
   output word_t    haddrd,
   output logic     htransd,
   output logic     hwrited,
   output hsize_t   hsized,
   output word_t    hwdatad,
   input  word_t    hrdatad,
   input  logic     hreadyd,

   // Load writeback
   output logic     load_valid,
   output word_t    load_data,
   output reg_idx_t load_rd
);

   logic     accept;
   logic     ph_load;
   lane_t    ph_lane;
   hsize_t   ph_size;
   logic     ph_unsigned;
   reg_idx_t ph_rd;

   //==========================================================================
   // Address phase and acceptance
   //==========================================================================

   lsu_addr_phase i_addr_phase (
      .clk         (clk),
      .rst_n       (rst_n),
      .req         (req),
      .write       (write),
      .unsigned_ld (unsigned_ld),
      .size        (size),
      .addr        (addr),
      .rd_idx      (rd_idx),
      .hreadyd     (hreadyd),
      .haddrd      (haddrd),
      .htransd     (htransd),
      .hwrited     (hwrited),
      .hsized      (hsized),
      .accept      (accept),
      .ph_load     (ph_load),
      .ph_lane     (ph_lane),
      .ph_size     (ph_size),
      .ph_unsigned (ph_unsigned),
      .ph_rd       (ph_rd)
   );

   //==========================================================================
   // Store data
   //==========================================================================

   lsu_store_align i_store_align (
      .clk     (clk),
      .rst_n   (rst_n),
      .accept  (accept),
      .size    (size),
      .lane    (addr[LANE_WIDTH-1:0]),
      .wdata   (wdata),
      .hwdatad (hwdatad)
   );

   //==========================================================================
   // Load data
   //==========================================================================

   lsu_load_extract i_load_extract (
      .ph_load     (ph_load),
      .ph_lane     (ph_lane),
      .ph_size     (ph_size),
      .ph_unsigned (ph_unsigned),
      .ph_rd       (ph_rd),
      .hrdatad     (hrdatad),
      .hreadyd     (hreadyd),
      .load_valid  (load_valid),
      .load_data   (load_data),
      .load_rd     (load_rd)
   );

endmodule : lsu_top

/* verif/lsu_chk.sv */
// Bus protocol assertions bound into lsu_top; checks are disabled while rst_n is low
`timescale 1ns/1ps

module lsu_chk
   import lsu_pkg::*;
(
   input logic   clk,
   input logic   rst_n,
   input logic   hreadyd,
   input logic   htransd,
   input logic   hwrited,
   input hsize_t hsized,
   input word_t  hwdatad,
   input logic   load_valid
);

   //==========================================================================
   // Data phase
   //==========================================================================

   // Writeback only in the ready cycle
   a_valid_ready: assert property (@(posedge clk) disable iff (!rst_n)
      load_valid |-> hreadyd)
      else $error("load_valid high while hreadyd is low");

   // Write data held through wait states
   a_wdata_hold: assert property (@(posedge clk) disable iff (!rst_n)
      !hreadyd |=> $stable(hwdatad))
      else $error("hwdatad changed during a wait state");

   //==========================================================================
   // Address phase
   //==========================================================================

   a_size_legal: assert property (@(posedge clk) disable iff (!rst_n)
      htransd |-> (hsized <= SIZE_WORD))
      else $error("hsized above word size");

   a_write_trans: assert property (@(posedge clk) disable iff (!rst_n)
      hwrited |-> htransd)
      else $error("hwrited without htransd");

endmodule : lsu_chk

bind lsu_top lsu_chk i_lsu_chk (.*);

/* verif/lsu_tb.sv */
// Random aligned accesses to a 16-word slave; hreadyd stalls only while a data phase is pending
`timescale 1ns/1ps

module lsu_tb;
   import lsu_pkg::*;

   localparam int CLK_PERIOD = 100;
   localparam int N_ACC      = 400;
   localparam int MAX_GAP    = 3;
   localparam int MAX_WAIT   = 3;
   localparam int WDOG_CYCLES = N_ACC * (MAX_GAP + MAX_WAIT + 2) + 20;
   localparam word_t MEM_BASE = 32'h2000_0000;

   // Test indexes
   localparam int T_ADDR = 0;
   localparam int T_STORE = 1;
   localparam int T_LOAD = 2;
   localparam int T_WAIT = 3;
   localparam int T_ROUND = 4;

   typedef struct packed {
      logic     write;
      hsize_t   size;
      lane_t    lane;
      logic [3:0] word;
      word_t    wdata;
      logic     uns;
      reg_idx_t rd;
   } access_t;

   logic clk, rst_n, req, write, unsigned_ld;
   hsize_t size, hsized;
   word_t addr, wdata, haddrd, hwdatad, hrdatad, load_data;
   reg_idx_t rd_idx, load_rd;
   logic hreadyd = 1'b1;
   logic htransd, hwrited, load_valid;

   integer seed = 32'h709b;
   word_t mem [16];
   word_t ref_mem [16];
   logic stored [16];
   access_t exp_q [$];
   string test_name [5] = '{"address_phase", "store_lanes", "load_extract", "wait_states",
                            "round_trip"};
   int n_checks [5] = '{default: 0};
   int n_errors [5] = '{default: 0};
   int loads = 0;
   int pulses = 0;

   // Slave data-phase state
   logic dp_active = 1'b0;
   logic dp_write = 1'b0;
   word_t dp_addr = '0;
   hsize_t dp_size = '0;
   int wait_cnt = 0;

   lsu_top i_lsu_top (.*);

   assign hrdatad = dp_active ? mem[dp_addr[5:2]] : '0;

   //===========================================================================
   // Reference rules
   //===========================================================================

   function automatic logic [3:0] byte_en(hsize_t sz, lane_t ln);
      if (sz == SIZE_BYTE) return 4'b0001 << ln;
      else if (sz == SIZE_HALF) return ln[1] ? 4'b1100 : 4'b0011;
      else return 4'b1111;
   endfunction

   function automatic word_t lane_mask(logic [3:0] be);
      word_t m;
      for (int b = 0; b < 4; b++) m[8*b +: 8] = {8{be[b]}};
      return m;
   endfunction

   // Replicate the value over the word and keep the enabled lanes
   function automatic word_t expect_store(word_t wd, hsize_t sz, lane_t ln);
      word_t rep;
      if (sz == SIZE_BYTE) rep = {4{wd[7:0]}};
      else if (sz == SIZE_HALF) rep = {2{wd[15:0]}};
      else rep = wd;
      return rep & lane_mask(byte_en(sz, ln));
   endfunction

   function automatic word_t expect_load(word_t w, hsize_t sz, lane_t ln, logic uns);
      word_t sh;
      sh = w >> (ln * 8);
      if (sz == SIZE_BYTE) return uns ? {24'h0, sh[7:0]} : {{24{sh[7]}}, sh[7:0]};
      else if (sz == SIZE_HALF) return uns ? {16'h0, sh[15:0]} : {{16{sh[15]}}, sh[15:0]};
      else return w;
   endfunction

   task automatic check(input int t, input word_t exp, input word_t act);
      n_checks[t]++;
      if (exp !== act) begin
         n_errors[t]++;
         $display("Error: %s expected %h actual %h at %0t", test_name[t], exp, act, $time);
      end
   endtask

   //===========================================================================
   // Clock, watchdog, slave
   //===========================================================================

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD/2) clk = ~clk;
   end

   initial begin
      #(CLK_PERIOD * WDOG_CYCLES);
      $display("Watchdog expired before all accesses completed");
      $display("TB FAILED");
      $finish;
   end

   always @(posedge clk) begin : slave_model
      logic next_active;
      logic [3:0] be;
      if (rst_n) begin
         next_active = dp_active;
         if (hreadyd) begin
            // Enabled lanes of a store are written when the data phase completes
            if (dp_active && dp_write) begin
               be = byte_en(dp_size, dp_addr[1:0]);
               for (int b = 0; b < 4; b++)
                  if (be[b])
                     mem[dp_addr[5:2]][8*b +: 8] <= hwdatad[8*b +: 8];
            end
            dp_active <= htransd;
            dp_addr <= haddrd;
            dp_size <= hsized;
            dp_write <= hwrited;
            next_active = htransd;
         end
         if (next_active && wait_cnt < MAX_WAIT && ($unsigned($random(seed)) % 3) == 0) begin
            hreadyd <= 1'b0;
            wait_cnt <= wait_cnt + 1;
         end else begin
            hreadyd <= 1'b1;
            wait_cnt <= 0;
         end
      end
   end

   //===========================================================================
   // Monitor and scoreboard
   //===========================================================================

   always @(posedge clk) begin : monitor
      access_t cur;
      int t;
      if (rst_n) begin
         if (hreadyd && exp_q.size() > 0) begin
            cur = exp_q.pop_front();
            if (cur.write) begin
               check(T_STORE, expect_store(cur.wdata, cur.size, cur.lane), hwdatad);
               ref_mem[cur.word] = (ref_mem[cur.word] & ~lane_mask(byte_en(cur.size, cur.lane)))
                                   | expect_store(cur.wdata, cur.size, cur.lane);
               stored[cur.word] = 1'b1;
            end else begin
               t = stored[cur.word] ? T_ROUND : T_LOAD;
               check(t, 1, load_valid);
               check(t, expect_load(ref_mem[cur.word], cur.size, cur.lane, cur.uns), load_data);
               check(t, cur.rd, load_rd);
            end
         end
         if (load_valid) pulses++;
         if (req) begin
            check(T_ADDR, addr, haddrd);
            check(T_ADDR, 1, htransd);
            check(T_ADDR, write, hwrited);
            check(T_ADDR, size, hsized);
         end else begin
            // Idle bus even when write is left high
            check(T_ADDR, 0, htransd);
            check(T_ADDR, 0, hwrited);
         end
         if (req && hreadyd) begin
            exp_q.push_back({write, size, addr[1:0], addr[5:2], wdata, unsigned_ld, rd_idx});
            if (!write) loads++;
         end
      end
   end

   //===========================================================================
   // Stimulus and report
   //===========================================================================

   initial begin : stimulus
      int gap;
      int errs;
      int chks;
      hsize_t sz;
      lane_t ln;
      logic [3:0] wi;
      for (int i = 0; i < 16; i++) begin
         mem[i] = 32'h8040_2010 ^ (i * 32'h1357_9bdf);
         ref_mem[i] = mem[i];
         stored[i] = 1'b0;
      end
      rst_n = 1'b0;
      req = 1'b0;
      write = 1'b0;
      size = SIZE_WORD;
      unsigned_ld = 1'b0;
      addr = MEM_BASE;
      wdata = '0;
      rd_idx = '0;
      repeat (3) @(posedge clk);
      rst_n <= 1'b1;
      @(posedge clk);
      for (int n = 0; n < N_ACC; n++) begin
         wi = $unsigned($random(seed)) % 16;
         sz = hsize_t'($unsigned($random(seed)) % 3);
         if (sz == SIZE_BYTE) ln = $unsigned($random(seed)) % 4;
         else if (sz == SIZE_HALF) ln = ($unsigned($random(seed)) % 2) * 2;
         else ln = 2'd0;
         req <= 1'b1;
         write <= $random(seed);
         size <= sz;
         unsigned_ld <= $random(seed);
         addr <= MEM_BASE | {wi, ln};
         wdata <= $random(seed);
         rd_idx <= $random(seed);
         // Hold until the slave is ready
         do @(posedge clk); while (!hreadyd);
         gap = $unsigned($random(seed)) % (MAX_GAP + 1);
         if (gap > 0) begin
            req <= 1'b0;
            write <= $random(seed);
            repeat (gap) @(posedge clk);
         end
      end
      req <= 1'b0;
      write <= 1'b0;
      do @(posedge clk); while (exp_q.size() != 0);
      repeat (2) @(posedge clk);
      check(T_WAIT, loads, pulses);
      errs = 0;
      chks = 0;
      for (int t = 0; t < 5; t++) begin
         $display("Test %-14s %0d checks, %0d errors", test_name[t], n_checks[t], n_errors[t]);
         errs += n_errors[t];
         chks += n_checks[t];
      end
      $display("Total %0d checks, %0d errors, %0d loads, %0d pulses", chks, errs, loads, pulses);
      if (errs == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule : lsu_tb

/* verilog.f */
hdl/lsu_pkg.sv
hdl/lsu_addr_phase.sv
hdl/lsu_store_align.sv
hdl/lsu_load_extract.sv
hdl/lsu_top.sv
verif/lsu_chk.sv
verif/lsu_tb.sv
